// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int REG_ADDR_W = 5;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

  // R-type view of a 32-bit instruction word
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_fields_t;

endpackage

// File: common/rv_pipe_pkg.sv
package rv_pipe_pkg;

  localparam int XLEN = 64;

  // fetch -> decode
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } fd_t;

  // decode -> execute
  typedef struct packed {
    logic                              valid;
    logic [XLEN-1:0]                   pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]                   rs1_data;
    logic [XLEN-1:0]                   rs2_data;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              wen;
    logic [XLEN-1:0]                   imm;
    logic                              a_sel_pc;   // operand a from pc
    logic                              b_sel_imm;  // operand b from imm
    rv_isa_pkg::alu_op_e               alu_op;
    logic                              jump;
    logic                              branch;
    logic                              branch_ne;
  } de_t;

  // execute -> writeback
  typedef struct packed {
    logic                              valid;
    logic [XLEN-1:0]                   pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              wen;
    logic [XLEN-1:0]                   result;
  } ew_t;

  typedef struct packed {
    logic [XLEN-1:0]                   pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              wen;
    logic [XLEN-1:0]                   data;
  } retire_t;

endpackage

// File: decode/riscv_decode.sv
`timescale 1ns/1ps

module riscv_decode (
  input  logic             i_clk,
  input  rv_pipe_pkg::fd_t i_fd,
  input  rv_pipe_pkg::ew_t i_wb,
  output rv_pipe_pkg::de_t o_de
);

  localparam int XLEN = rv_pipe_pkg::XLEN;

  rv_isa_pkg::instr_fields_t f;
  logic [XLEN-1:0]           imm_i;
  logic [XLEN-1:0]           imm_u;
  logic [XLEN-1:0]           imm_j;
  logic [XLEN-1:0]           imm_b;
  logic [XLEN-1:0]           rs1_data;
  logic [XLEN-1:0]           rs2_data;
  logic                      sra_imm;

  function automatic rv_isa_pkg::alu_op_e map_alu_op(input logic [2:0] funct3,
                                                     input logic       alt);
    rv_isa_pkg::alu_op_e op;
    case (funct3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
      default:                op = rv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign f = i_fd.instr;

  assign imm_i = {{(XLEN-12){f.funct7[6]}}, i_fd.instr[31:20]};
  assign imm_u = {{(XLEN-32){f.funct7[6]}}, i_fd.instr[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){f.funct7[6]}}, i_fd.instr[31], i_fd.instr[19:12],
                  i_fd.instr[20], i_fd.instr[30:21], 1'b0};
  assign imm_b = {{(XLEN-13){f.funct7[6]}}, i_fd.instr[31], i_fd.instr[7],
                  i_fd.instr[30:25], i_fd.instr[11:8], 1'b0};

  // only srai takes bit 30 so addi never turns into sub
  assign sra_imm = f.funct7[5] && (f.funct3 == rv_isa_pkg::F3_SRL_SRA);

  riscv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rs1_addr (f.rs1),
    .i_rs2_addr (f.rs2),
    .i_wen      (i_wb.valid & i_wb.wen),
    .i_rd_addr  (i_wb.rd),
    .i_rd_data  (i_wb.result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  always_comb begin
    o_de           = '0;
    o_de.valid     = i_fd.valid;
    o_de.pc        = i_fd.pc;
    o_de.rs1_addr  = f.rs1;
    o_de.rs2_addr  = f.rs2;
    o_de.rs1_data  = rs1_data;
    o_de.rs2_data  = rs2_data;
    o_de.rd        = f.rd;
    o_de.alu_op    = rv_isa_pkg::ALU_ADD;
    case (f.opcode)
      rv_isa_pkg::OPC_OP: begin
        o_de.wen    = i_fd.valid;
        o_de.alu_op = map_alu_op(f.funct3, f.funct7[5]);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        o_de.wen       = i_fd.valid;
        o_de.imm       = imm_i;
        o_de.b_sel_imm = 1'b1;
        o_de.alu_op    = map_alu_op(f.funct3, sra_imm);
      end
      rv_isa_pkg::OPC_LUI: begin
        o_de.wen       = i_fd.valid;
        o_de.imm       = imm_u;
        o_de.b_sel_imm = 1'b1;
        o_de.alu_op    = rv_isa_pkg::ALU_PASS_B;
      end
      rv_isa_pkg::OPC_JAL: begin  // alu makes the target and the link is pc+4
        o_de.wen       = i_fd.valid;
        o_de.jump      = i_fd.valid;
        o_de.imm       = imm_j;
        o_de.a_sel_pc  = 1'b1;
        o_de.b_sel_imm = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_de.branch    = i_fd.valid && (f.funct3 == rv_isa_pkg::F3_BEQ ||
                                        f.funct3 == rv_isa_pkg::F3_BNE);
        o_de.branch_ne = (f.funct3 == rv_isa_pkg::F3_BNE);
        o_de.imm       = imm_b;
        o_de.a_sel_pc  = 1'b1;
        o_de.b_sel_imm = 1'b1;
      end
      default: ;  // unsupported opcode neither writes nor branches
    endcase
  end

endmodule

// File: decode/riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile (
  input  logic                              i_clk,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  input  logic                              i_wen,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic [rv_pipe_pkg::XLEN-1:0]      i_rd_data,
  output logic [rv_pipe_pkg::XLEN-1:0]      o_rs1_data,
  output logic [rv_pipe_pkg::XLEN-1:0]      o_rs2_data
);

  logic [rv_pipe_pkg::XLEN-1:0] regs [31:1];  // x0 not stored
  logic                         wr_live;

  assign wr_live = i_wen && (i_rd_addr != '0);

  always_ff @(posedge i_clk) begin
    if (wr_live) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // write-through so a same-cycle reader sees the new value
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (wr_live && i_rs1_addr == i_rd_addr) ? i_rd_data :
                      regs[i_rs1_addr];

  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (wr_live && i_rs2_addr == i_rd_addr) ? i_rd_data :
                      regs[i_rs2_addr];

endmodule

// File: design/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
  parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic [31:0]                   i_imem_data,
  input  logic                          i_imem_ready,
  output logic [rv_pipe_pkg::XLEN-1:0]  o_imem_addr,
  output logic                          o_retire_valid,
  output rv_pipe_pkg::retire_t          o_retire
);

  rv_pipe_pkg::fd_t             fd_d;
  rv_pipe_pkg::fd_t             fd_q;
  rv_pipe_pkg::de_t             de_d;
  rv_pipe_pkg::de_t             de_q;
  rv_pipe_pkg::ew_t             ew_d;
  rv_pipe_pkg::ew_t             ew_q;
  logic                         redirect;
  logic [rv_pipe_pkg::XLEN-1:0] redirect_pc;

  riscv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_imem_ready  (i_imem_ready),
    .i_imem_data   (i_imem_data),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_pc          (o_imem_addr),
    .o_fd          (fd_d)
  );

  riscv_pipe_reg #(.payload_t(rv_pipe_pkg::fd_t)) u_fd_reg (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_flush (redirect),  // kills the instruction in fetch
    .i_d     (fd_d),
    .o_q     (fd_q)
  );

  riscv_decode u_decode (
    .i_clk (i_clk),
    .i_fd  (fd_q),
    .i_wb  (ew_q),  // regfile write port
    .o_de  (de_d)
  );

  riscv_pipe_reg #(.payload_t(rv_pipe_pkg::de_t)) u_de_reg (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_flush (redirect),  // kills the instruction in decode
    .i_d     (de_d),
    .o_q     (de_q)
  );

  riscv_execute u_execute (
    .i_de          (de_q),
    .i_wb          (ew_q),
    .o_ew          (ew_d),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  // the oldest stage is never flushed
  riscv_pipe_reg #(.payload_t(rv_pipe_pkg::ew_t)) u_ew_reg (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_flush (1'b0),
    .i_d     (ew_d),
    .o_q     (ew_q)
  );

  // retire port reports what writeback commits this cycle
  assign o_retire_valid = ew_q.valid;

  always_comb begin
    o_retire.pc   = ew_q.pc;
    o_retire.rd   = ew_q.rd;
    o_retire.wen  = ew_q.wen;
    o_retire.data = ew_q.result;
  end

endmodule

// File: design/riscv_fetch.sv
`timescale 1ns/1ps

module riscv_fetch #(
  parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_imem_ready,
  input  logic [31:0]                   i_imem_data,
  input  logic                          i_redirect,
  input  logic [rv_pipe_pkg::XLEN-1:0]  i_redirect_pc,
  output logic [rv_pipe_pkg::XLEN-1:0]  o_pc,
  output rv_pipe_pkg::fd_t              o_fd
);

  logic [rv_pipe_pkg::XLEN-1:0] pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= RESET_PC;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;  // branch / jump from execute wins
    end else if (i_imem_ready) begin
      pc <= pc + rv_pipe_pkg::XLEN'(4);
    end
  end

  assign o_pc = pc;

  // wrong-path fetch is dropped while execute redirects
  always_comb begin
    o_fd.valid = i_imem_ready & ~i_redirect;
    o_fd.pc    = pc;
    o_fd.instr = i_imem_data;
  end

endmodule

// File: design/riscv_pipe_reg.sv
`timescale 1ns/1ps

module riscv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_flush,
  input  payload_t i_d,
  output payload_t o_q
);

  // flush turns the whole slot into a bubble
  always_ff @(posedge i_clk) begin
    if (i_reset || i_flush) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

endmodule

// File: execute/riscv_execute.sv
`timescale 1ns/1ps

module riscv_execute (
  input  rv_pipe_pkg::de_t             i_de,
  input  rv_pipe_pkg::ew_t             i_wb,
  output rv_pipe_pkg::ew_t             o_ew,
  output logic                         o_redirect,
  output logic [rv_pipe_pkg::XLEN-1:0] o_redirect_pc
);

  localparam int XLEN    = rv_pipe_pkg::XLEN;
  localparam int SHAMT_W = $clog2(XLEN);

  logic              wb_fwd;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   op_a;
  logic [XLEN-1:0]   op_b;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]   alu_res;
  logic              rs_equal;
  logic              taken;

  // writeback register is the only forwarding source
  assign wb_fwd  = i_wb.valid && i_wb.wen && (i_wb.rd != '0);
  assign rs1_val = (wb_fwd && i_wb.rd == i_de.rs1_addr) ? i_wb.result : i_de.rs1_data;
  assign rs2_val = (wb_fwd && i_wb.rd == i_de.rs2_addr) ? i_wb.result : i_de.rs2_data;

  assign op_a  = i_de.a_sel_pc  ? i_de.pc  : rs1_val;
  assign op_b  = i_de.b_sel_imm ? i_de.imm : rs2_val;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (i_de.alu_op)
      rv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_isa_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_isa_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_isa_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      rv_isa_pkg::ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_isa_pkg::ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = '0;
    endcase
  end

  // branch compare always uses the register operands
  assign rs_equal = (rs1_val == rs2_val);
  assign taken    = i_de.jump | (i_de.branch & (rs_equal ^ i_de.branch_ne));

  assign o_redirect    = taken;
  assign o_redirect_pc = alu_res;  // pc + imm for jal and branches

  always_comb begin
    o_ew.valid  = i_de.valid;
    o_ew.pc     = i_de.pc;
    o_ew.rd     = i_de.rd;
    o_ew.wen    = i_de.wen;
    o_ew.result = i_de.jump ? i_de.pc + XLEN'(4) : alu_res;  // link value
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_riscv_core \
  -f vlog.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^TEST RESULT: PASS$" && exit 0 || exit 1

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk   = 1'b0;
    o_reset = 1'b1;
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

  // release on a falling edge away from the rising edge the core samples
  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

// File: verification/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;

  localparam int XLEN      = rv_pipe_pkg::XLEN;
  localparam int MEM_WORDS = 256;
  localparam int MAX_EXP   = 256;

  logic                 clk;
  logic                 reset;
  logic [31:0]          imem_data;
  logic                 imem_ready;
  logic [XLEN-1:0]      imem_addr;
  logic                 retire_valid;
  rv_pipe_pkg::retire_t retire;

  logic [31:0]     mem      [0:MEM_WORDS-1];
  logic [XLEN-1:0] shadow   [0:31];  // architectural model of x0..x31
  logic [XLEN-1:0] exp_pc   [0:MAX_EXP-1];
  logic [4:0]      exp_rd   [0:MAX_EXP-1];
  logic            exp_wen  [0:MAX_EXP-1];
  logic [XLEN-1:0] exp_data [0:MAX_EXP-1];

  int              exp_count = 0;
  int              head = 0;  // next expected retire
  int              errors = 0;
  int              cycles = 0;
  int              limit = 0;
  integer          seed;
  logic [31:0]     ready_rnd;
  logic            post_reset = 1'b0;
  logic [XLEN-1:0] build_pc;
  logic [XLEN-1:0] prog_end = '0;
  logic [XLEN-1:0] head_pc;
  logic [4:0]      head_rd;
  logic            head_wen;
  logic [XLEN-1:0] head_data;
  logic            check_now;

  tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clkgen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  riscv_core #(.RESET_PC('0)) dut0 (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_imem_data    (imem_data),
    .i_imem_ready   (imem_ready),
    .o_imem_addr    (imem_addr),
    .o_retire_valid (retire_valid),
    .o_retire       (retire)
  );

  // opcode 0 is a no-op for the core, upper bits hold a fold of the address
  function automatic logic [31:0] fill_word(input logic [XLEN-1:0] addr);
    logic [24:0] fold;
    fold = addr[24:0] ^ addr[49:25] ^ {11'b0, addr[63:50]};
    return {fold, 7'b0000000};
  endfunction

  assign imem_data = (imem_addr < XLEN'(MEM_WORDS * 4)) ? mem[imem_addr[9:2]] :
                     fill_word(imem_addr);

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
  endfunction

  // RV64 integer semantics with the shift amount in the low 6 bits
  function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: r = alt ? a - b : a + b;
      rv_isa_pkg::F3_SLL:     r = a << b[5:0];
      rv_isa_pkg::F3_SLT:     r = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
      rv_isa_pkg::F3_SLTU:    r = (a < b) ? XLEN'(1) : '0;
      rv_isa_pkg::F3_XOR:     r = a ^ b;
      rv_isa_pkg::F3_SRL_SRA: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      rv_isa_pkg::F3_OR:      r = a | b;
      default:                r = a & b;
    endcase
    return r;
  endfunction

  task automatic emit(input logic [31:0] word, input logic wen, input logic [4:0] rd,
                      input logic [XLEN-1:0] data);
    mem[build_pc[9:2]]  = word;
    exp_pc[exp_count]   = build_pc;
    exp_rd[exp_count]   = rd;
    exp_wen[exp_count]  = wen;
    exp_data[exp_count] = data;
    exp_count++;
    if (wen && rd != 5'd0) shadow[rd] = data;  // x0 stays zero
    build_pc += XLEN'(4);
  endtask

  // slot that a taken branch or jump must skip
  task automatic place_skipped();
    mem[build_pc[9:2]] = encode_i(12'h123, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd1);
    build_pc += XLEN'(4);
  endtask

  task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
    logic [XLEN-1:0] res;
    res = ref_alu(f3, alt, shadow[rs1], shadow[rs2]);
    emit(encode_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd), 1'b1, rd, res);
  endtask

  task automatic op_i(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [11:0] imm_in);
    logic [11:0]     imm;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    imm = imm_in;
    if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL_SRA) begin
      imm = {alt ? 6'b010000 : 6'b000000, imm_in[5:0]};  // shamt form
    end
    b   = {{(XLEN-12){imm[11]}}, imm};
    res = ref_alu(f3, alt, shadow[rs1], b);
    emit(encode_i(imm, rs1, f3, rd), 1'b1, rd, res);
  endtask

  task automatic op_lui(input logic [4:0] rd, input logic [19:0] imm20);
    emit({imm20, rd, rv_isa_pkg::OPC_LUI}, 1'b1, rd, {{(XLEN-32){imm20[19]}}, imm20, 12'b0});
  endtask

  task automatic op_jal(input logic [4:0] rd, input int off);
    logic [XLEN-1:0] target;
    target = build_pc + XLEN'(off);
    emit(encode_j(21'(off), rd), 1'b1, rd, build_pc + XLEN'(4));
    while (build_pc != target) place_skipped();
  endtask

  task automatic op_branch(input logic ne, input logic [4:0] rs1, input logic [4:0] rs2);
    logic taken;
    taken = (shadow[rs1] == shadow[rs2]) ^ ne;
    emit(encode_b(13'd12, rs2, rs1, ne ? rv_isa_pkg::F3_BNE : rv_isa_pkg::F3_BEQ),
         1'b0, 5'd0, '0);
    if (taken) begin
      place_skipped();
      place_skipped();
    end
  endtask

  // each op reads the previous result to exercise forwarding
  task automatic chain_ops(input int n, input logic [4:0] start_rs);
    logic [31:0] rnd;
    logic [4:0]  src;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    int          k;
    src = start_rs;
    for (k = 0; k < n; k++) begin
      rnd = $random(seed);
      rd  = {2'b00, rnd[2:0]} + 5'd1;
      rs2 = {2'b00, rnd[5:3]};
      f3  = rnd[10:8];
      alt = rnd[11] && (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA);
      if (rnd[12]) begin
        op_i(f3, alt && f3 != rv_isa_pkg::F3_ADD_SUB, rd, src, rnd[24:13]);
      end else begin
        op_r(f3, alt, rd, src, rs2);
      end
      src = rd;
    end
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    int          r;
    build_pc = '0;
    for (r = 1; r < 16; r++) begin  // give every used register a value
      rnd = $random(seed);
      op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'(r), 5'd0, rnd[11:0]);
    end
    op_lui(5'd3, 20'h81234);
    op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd3, 5'd3, 12'hfff);
    op_lui(5'd4, 20'h7abcd);
    chain_ops(24, 5'd3);
    op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 12'h055);  // x0 write retires
    op_r(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd9, 5'd0, 5'd1);     // but reads zero
    op_r(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd0, 5'd2, 5'd3);
    op_r(rv_isa_pkg::F3_OR, 1'b0, 5'd9, 5'd0, 5'd9);
    op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd10, 5'd0, 12'd1);
    op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd11, 5'd0, 12'd2);
    op_branch(1'b0, 5'd10, 5'd10);  // beq taken
    op_branch(1'b1, 5'd10, 5'd11);  // bne taken
    op_branch(1'b0, 5'd10, 5'd11);  // beq falls through
    op_branch(1'b1, 5'd11, 5'd11);  // bne falls through
    op_r(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd10, 5'd10, 5'd11);
    op_jal(5'd12, 12);
    op_r(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd13, 5'd12, 5'd12);  // reads the link value
    op_jal(5'd0, 8);
    op_branch(1'b1, 5'd1, 5'd13);
    chain_ops(8, 5'd12);
    op_i(rv_isa_pkg::F3_ADD_SUB, 1'b0, 5'd14, 5'd12, 12'd1);
    prog_end = build_pc;
  endtask

  assign head_pc   = exp_pc[head];
  assign head_rd   = exp_rd[head];
  assign head_wen  = exp_wen[head];
  assign head_data = exp_data[head];
  assign check_now = retire_valid && (retire.pc < prog_end);  // fill area ignored

  always @(posedge clk) begin
    post_reset <= reset;
    if (reset) begin
      head <= 0;
    end else if (check_now) begin
      head <= head + 1;
    end
  end

  always @(negedge clk) begin
    ready_rnd = $random(seed);
    if (!reset && head * 2 >= exp_count) begin
      imem_ready <= (ready_rnd[1:0] != 2'b00);  // second half with gaps
    end else begin
      imem_ready <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(negedge clk)
    (reset || post_reset) |-> (!retire_valid && imem_addr == '0))
    else begin
      errors++;
      $display("Error: %0t core not idle at pc 0 around reset, addr=%h", $time, imem_addr);
    end

  a_no_extra: assert property (@(negedge clk) disable iff (reset)
    check_now |-> (head < exp_count))
    else begin
      errors++;
      $display("Unexpected retire at time %0t with pc %h after the program", $time, retire.pc);
    end

  a_pc: assert property (@(negedge clk) disable iff (reset)
    (check_now && head < exp_count) |-> (retire.pc == head_pc))
    else begin
      errors++;
      $display("Error: %0t retire pc %h, expected %h", $time, retire.pc, head_pc);
    end

  a_wen: assert property (@(negedge clk) disable iff (reset)
    (check_now && head < exp_count) |-> (retire.wen == head_wen))
    else begin
      errors++;
      $display("Error: %0t retire wen %b at pc %h, expected %b", $time, retire.wen,
               retire.pc, head_wen);
    end

  a_rd: assert property (@(negedge clk) disable iff (reset)
    (check_now && head < exp_count && head_wen) |-> (retire.rd == head_rd))
    else begin
      errors++;
      $display("Error: %0t retire rd %0d at pc %h, expected %0d", $time, retire.rd,
               retire.pc, head_rd);
    end

  a_data: assert property (@(negedge clk) disable iff (reset)
    (check_now && head < exp_count && head_wen) |-> (retire.data == head_data))
    else begin
      errors++;
      $display("Error: %0t retire data %h at pc %h, expected %h", $time, retire.data,
               retire.pc, head_data);
    end

  initial begin
    imem_ready = 1'b0;
    seed       = 32'h7f14;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(XLEN'(i * 4));
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    build_program();
    limit = 4 * int'(prog_end >> 2) + 40;
    @(negedge reset);
    while (head < exp_count && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk);  // wrong-path retires would show up here
    @(negedge clk);
    if (cycles >= limit) begin
      $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
               head, exp_count, limit);
    end
    $display("Summary: errors=%0d retired=%0d expected=%0d cycles=%0d",
             errors, head, exp_count, cycles);
    if (errors == 0 && head == exp_count && cycles < limit) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
design/riscv_fetch.sv
design/riscv_pipe_reg.sv
decode/riscv_regfile.sv
decode/riscv_decode.sv
execute/riscv_execute.sv
design/riscv_core.sv
verification/tb_clkgen.sv
verification/tb_riscv_core.sv
